//--- common/display_pkg.sv
package display_pkg;

  // widths with a meaning
  typedef logic [15:0]  pixel_t;        // rgb565 with red on top
  typedef logic [127:0] chunk_t;        // eight pixels with slot 0 in bits 15:0
  typedef logic [7:0]   color_t;        // one expanded channel
  typedef logic [6:0]   hcount_t;
  typedef logic [2:0]   vcount_t;
  typedef logic [7:0]   pix_index_t;    // pixel number within a frame
  typedef logic [1:0]   pattern_sel_t;

  localparam int PIX_PER_CHUNK = 8;

  // raster scaled down for simulation
  localparam int H_ACTIVE = 64;
  localparam int H_TOTAL  = 80;
  localparam int HS_START = 68;
  localparam int HS_END   = 72;         // first count past the pulse
  localparam int V_ACTIVE = 4;
  localparam int V_TOTAL  = 6;
  localparam int VS_START = 5;
  localparam int VS_END   = 6;

  localparam int FRAME_PIXELS = H_ACTIVE * V_ACTIVE;            // 256
  localparam int FRAME_CHUNKS = FRAME_PIXELS / PIX_PER_CHUNK;   // 32

  localparam int FIFO_DEPTH = 8;        // in chunks

  localparam pixel_t DEFAULT_PIXEL = 16'hF800;  // pure red

  // entry 0 is the leftmost bar
  localparam logic [7:0][15:0] BAR_COLORS = {
    16'h0000,   // 7 black
    16'h001F,   // 6 blue
    16'hF800,   // 5 red
    16'hF81F,   // 4 magenta
    16'h07E0,   // 3 green
    16'h07FF,   // 2 cyan
    16'hFFE0,   // 1 yellow
    16'hFFFF    // 0 white
  };

endpackage

//--- common/stream_if.sv
interface stream_if #(
  parameter int WIDTH = $bits(display_pkg::chunk_t)
);

  // one item moves on each cycle with valid and ready high
  logic             valid;
  logic             ready;
  logic [WIDTH-1:0] data;
  logic             last;   // final item of a frame

  modport source (
    output valid,
    output data,
    output last,
    input  ready
  );

  modport sink (
    input  valid,
    input  data,
    input  last,
    output ready
  );

endinterface

//--- common/video_timing_if.sv
interface video_timing_if;

  display_pkg::hcount_t hcount;
  display_pkg::vcount_t vcount;
  logic                 active;     // inside the drawn area
  logic                 hsync;
  logic                 vsync;
  logic                 final_pos;  // last active pixel of the frame

  modport source (
    output hcount, vcount, active, hsync, vsync, final_pos
  );

  modport sink (
    input  hcount, vcount, active, hsync, vsync, final_pos
  );

endinterface

//--- rtl/pattern_stacker.sv
module pattern_stacker (
  input  logic                      clk_camera,
  input  logic                      recent_reset,
  input  display_pkg::pattern_sel_t pattern_sel_i,
  stream_if.source                  chunk_o
);

  display_pkg::pix_index_t   base;        // first pixel of the offered chunk
  display_pkg::pix_index_t   build_base;  // first pixel of the next chunk
  display_pkg::pattern_sel_t pat_q;       // pattern of the current frame
  display_pkg::pattern_sel_t build_sel;
  display_pkg::chunk_t       chunk_next;
  logic                      load;

  // one pixel of the selected test pattern
  function automatic display_pkg::pixel_t pattern_pixel(
    input display_pkg::pattern_sel_t sel,
    input display_pkg::pix_index_t   p
  );
    logic [5:0] x;
    logic [1:0] y;
    x = p[5:0];   // p mod 64
    y = p[7:6];   // p / 64
    case (sel)
      2'd0:    return display_pkg::BAR_COLORS[x[5:3]];  // bar of width 8
      2'd1:    return {x[5:1], x, y, 3'b000};  // r = x/2, g = x, b = y*8
      2'd2:    return (x[3] ^ y[0]) ? 16'hFFFF : 16'h0000;  // checker
      default: return 16'h001F;                // solid blue
    endcase
  endfunction

  assign load = !chunk_o.valid || chunk_o.ready;  // empty or chunk taken

  always_comb begin
    // first chunk after reset starts at 0 and later ones step by 8
    if (!chunk_o.valid) begin
      build_base = base;
    end else if (int'(base) + display_pkg::PIX_PER_CHUNK >= display_pkg::FRAME_PIXELS) begin
      build_base = '0;  // wrap into the next frame
    end else begin
      build_base = display_pkg::pix_index_t'(int'(base) + display_pkg::PIX_PER_CHUNK);
    end
    build_sel = (build_base == '0) ? pattern_sel_i : pat_q;  // latch on chunk 0 only
    for (int i = 0; i < display_pkg::PIX_PER_CHUNK; i++) begin
      chunk_next[i*16 +: 16] = pattern_pixel(build_sel,
                                             display_pkg::pix_index_t'(int'(build_base) + i));
    end
  end

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      chunk_o.valid <= 1'b0;
      base          <= '0;
      pat_q         <= '0;
    end else if (load) begin
      chunk_o.valid <= 1'b1;
      base          <= build_base;
      pat_q         <= build_sel;
    end
  end

  // payload held while stalled
  always_ff @(posedge clk_camera) begin
    if (load) begin
      chunk_o.data <= chunk_next;
      chunk_o.last <= (int'(build_base) / display_pkg::PIX_PER_CHUNK
                       == display_pkg::FRAME_CHUNKS - 1);  // chunk 31
    end
  end

endmodule

//--- rtl/chunk_fifo.sv
module chunk_fifo (
  input  logic     clk_camera,
  input  logic     recent_reset,
  stream_if.sink   chunk_in,
  stream_if.source chunk_out
);

  display_pkg::chunk_t mem_data [display_pkg::FIFO_DEPTH];
  logic                mem_last [display_pkg::FIFO_DEPTH];

  logic [$clog2(display_pkg::FIFO_DEPTH)-1:0]   wr_ptr;
  logic [$clog2(display_pkg::FIFO_DEPTH)-1:0]   rd_ptr;
  logic [$clog2(display_pkg::FIFO_DEPTH+1)-1:0] count;   // 0 .. depth
  logic                                         push;
  logic                                         pop;

  assign chunk_in.ready  = (count != display_pkg::FIFO_DEPTH);  // back-pressure when full
  assign chunk_out.valid = (count != '0);
  assign chunk_out.data  = mem_data[rd_ptr];  // head of queue
  assign chunk_out.last  = mem_last[rd_ptr];

  assign push = chunk_in.valid && chunk_in.ready;
  assign pop  = chunk_out.valid && chunk_out.ready;

  // storage array
  always_ff @(posedge clk_camera) begin
    if (push) begin
      mem_data[wr_ptr] <= chunk_in.data;
      mem_last[wr_ptr] <= chunk_in.last;  // last travels with its chunk
    end
  end

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;  // wraps since depth is a power of two
      if (pop)  rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;          // both or neither
      endcase
    end
  end

endmodule

//--- rtl/unstacker.sv
module unstacker (
  input  logic     clk_camera,
  input  logic     recent_reset,
  stream_if.sink   chunk_in,
  stream_if.source pixel_o
);

  display_pkg::chunk_t                           chunk_q;
  logic                                          chunk_last_q;  // held chunk ends a frame
  logic [$clog2(display_pkg::PIX_PER_CHUNK)-1:0] slot;
  logic                                          full;
  logic                                          last_slot;
  logic                                          pix_hs;
  logic                                          chunk_hs;

  assign last_slot = (slot == display_pkg::PIX_PER_CHUNK - 1);
  assign pix_hs    = pixel_o.valid && pixel_o.ready;

  // refill when empty or as the eighth pixel leaves
  assign chunk_in.ready = !full || (pixel_o.ready && last_slot);
  assign chunk_hs       = chunk_in.valid && chunk_in.ready;

  assign pixel_o.valid = full;
  assign pixel_o.data  = chunk_q[slot*$bits(display_pkg::pixel_t) +: $bits(display_pkg::pixel_t)];
  assign pixel_o.last  = chunk_last_q && last_slot;  // slot 7 of the frame's last chunk

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      full <= 1'b0;
      slot <= '0;
    end else if (chunk_hs) begin
      full <= 1'b1;           // new chunk wins over draining the old one
      slot <= '0;             // lowest slot first
    end else if (pix_hs) begin
      slot <= slot + 1'b1;
      if (last_slot) begin
        full <= 1'b0;         // drained with nothing waiting
      end
    end
  end

  // held chunk and its last flag
  always_ff @(posedge clk_camera) begin
    if (chunk_hs) begin
      chunk_q      <= chunk_in.data;
      chunk_last_q <= chunk_in.last;
    end
  end

endmodule

//--- rtl/video_timing.sv
module video_timing (
  input  logic            clk_camera,
  input  logic            recent_reset,
  video_timing_if.source  timing_o
);

  display_pkg::hcount_t hcount;
  display_pkg::vcount_t vcount;
  logic                 running;   // low through reset and one cycle after
  logic                 line_end;

  assign line_end = (hcount == display_pkg::H_TOTAL - 1);

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      running <= 1'b0;
      hcount  <= '0;
      vcount  <= '0;
    end else begin
      running <= 1'b1;
      if (running) begin
        if (line_end) begin
          hcount <= '0;
          // next line and wrap at end of frame
          vcount <= (vcount == display_pkg::V_TOTAL - 1) ? '0 : vcount + 1'b1;
        end else begin
          hcount <= hcount + 1'b1;
        end
      end
    end
  end

  assign timing_o.hcount = hcount;
  assign timing_o.vcount = vcount;

  // levels follow the count in the same cycle
  assign timing_o.active = running
                           && (hcount < display_pkg::H_ACTIVE)
                           && (vcount < display_pkg::V_ACTIVE);
  assign timing_o.hsync  = running
                           && (hcount >= display_pkg::HS_START)
                           && (hcount < display_pkg::HS_END);
  assign timing_o.vsync  = running
                           && (vcount >= display_pkg::VS_START)
                           && (vcount < display_pkg::VS_END);

  // bottom right corner of the drawn area
  assign timing_o.final_pos = timing_o.active
                              && (hcount == display_pkg::H_ACTIVE - 1)
                              && (vcount == display_pkg::V_ACTIVE - 1);

endmodule

//--- rtl/pixel_output.sv
module pixel_output (
  input  logic                clk_camera,
  input  logic                recent_reset,
  stream_if.sink              pixel_i,
  video_timing_if.sink        timing_i,
  output display_pkg::color_t red_o,
  output display_pkg::color_t green_o,
  output display_pkg::color_t blue_o,
  output logic                hsync_o,
  output logic                vsync_o,
  output logic                active_o
);

  display_pkg::pixel_t shown;   // pixel picked for this position
  logic                take;

  // the frame's last pixel waits for the final active position,
  // so every frame restarts at the top left corner
  assign pixel_i.ready = timing_i.active && (!pixel_i.last || timing_i.final_pos);
  assign take          = pixel_i.valid && pixel_i.ready;
  assign shown         = take ? pixel_i.data : display_pkg::DEFAULT_PIXEL;  // red if starved

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      red_o    <= '0;
      green_o  <= '0;
      blue_o   <= '0;
      hsync_o  <= 1'b0;
      vsync_o  <= 1'b0;
      active_o <= 1'b0;
    end else begin
      red_o    <= {shown[15:11], 3'b000};  // 5 bits to the top
      green_o  <= {shown[10:5], 2'b00};    // 6 bits
      blue_o   <= {shown[4:0], 3'b000};
      hsync_o  <= timing_i.hsync;          // delayed to line up with color
      vsync_o  <= timing_i.vsync;
      active_o <= timing_i.active;
    end
  end

endmodule

//--- rtl/pattern_display_top.sv
module pattern_display_top (
  input  logic                      clk_camera,
  input  logic                      recent_reset,
  input  display_pkg::pattern_sel_t pattern_sel_i,
  output display_pkg::color_t       red_o,
  output display_pkg::color_t       green_o,
  output display_pkg::color_t       blue_o,
  output logic                      hsync_o,
  output logic                      vsync_o,
  output logic                      active_o
);

  stream_if #(.WIDTH($bits(display_pkg::chunk_t))) chunk_in_if ();   // stacker to fifo
  stream_if #(.WIDTH($bits(display_pkg::chunk_t))) chunk_out_if ();  // fifo to unstacker
  stream_if #(.WIDTH($bits(display_pkg::pixel_t))) pixel_if ();      // pixels to output
  video_timing_if                                  timing_if ();

  pattern_stacker u_pattern_stacker (
    .clk_camera    (clk_camera),
    .recent_reset  (recent_reset),
    .pattern_sel_i (pattern_sel_i),
    .chunk_o       (chunk_in_if)
  );

  // stands in for the memory path
  chunk_fifo u_chunk_fifo (
    .clk_camera   (clk_camera),
    .recent_reset (recent_reset),
    .chunk_in     (chunk_in_if),
    .chunk_out    (chunk_out_if)
  );

  unstacker u_unstacker (
    .clk_camera   (clk_camera),
    .recent_reset (recent_reset),
    .chunk_in     (chunk_out_if),
    .pixel_o      (pixel_if)
  );

  video_timing u_video_timing (
    .clk_camera   (clk_camera),
    .recent_reset (recent_reset),
    .timing_o     (timing_if)
  );

  pixel_output u_pixel_output (
    .clk_camera   (clk_camera),
    .recent_reset (recent_reset),
    .pixel_i      (pixel_if),
    .timing_i     (timing_if),
    .red_o        (red_o),
    .green_o      (green_o),
    .blue_o       (blue_o),
    .hsync_o      (hsync_o),
    .vsync_o      (vsync_o),
    .active_o     (active_o)
  );

endmodule

//--- bench/tb_clock.sv
module tb_clock #(
  parameter int PERIOD = 100
) (
  output logic clk_o
);

  initial clk_o = 1'b0;  // free running from low

  always #(PERIOD / 2) clk_o = ~clk_o;  // 50/50 duty

endmodule

//--- bench/pattern_display_sva.sv
module pattern_display_sva (
  input logic                      clk_camera,
  input logic                      recent_reset,
  input display_pkg::pattern_sel_t pattern_sel_i,
  input display_pkg::color_t       red_i,
  input display_pkg::color_t       green_i,
  input display_pkg::color_t       blue_i,
  input logic                      hsync_i,
  input logic                      vsync_i,
  input logic                      active_i
);

  localparam int FIRST_FRAME = 3;  // earlier frames may be misaligned

  int                        error_count = 0;
  logic                      hs_q;
  logic                      vs_q;
  logic                      act_q;
  logic                      hs_seen;      // gap valid after the first rise
  logic                      vs_seen;
  int                        hs_gap;       // cycles since the last rise
  int                        hs_len;       // high cycles so far
  int                        vs_gap;
  int                        px;           // column and run length of active
  int                        py;           // active lines since vsync
  int                        frame_cnt;    // vsync rises since reset
  int                        check_from;   // first frame that must match exp_sel
  display_pkg::pattern_sel_t sel_q;
  display_pkg::pattern_sel_t exp_sel;
  logic [23:0]               rgb;
  logic                      hs_rise;
  logic                      vs_rise;
  logic                      act_fall;

  assign rgb      = {red_i, green_i, blue_i};
  assign hs_rise  = hsync_i && !hs_q;
  assign vs_rise  = vsync_i && !vs_q;
  assign act_fall = !active_i && act_q;

  // pattern at column x, line y
  function automatic display_pkg::pixel_t ref_pixel(
    input display_pkg::pattern_sel_t sel,
    input int                        x,
    input int                        y
  );
    logic [4:0] r;
    logic [5:0] g;
    logic [4:0] b;
    r = 5'(x / 2);
    g = 6'(x);
    b = 5'(y * 8);
    case (sel)
      2'd0:    return display_pkg::BAR_COLORS[x / 8];     // bars 8 wide
      2'd1:    return {r, g, b};
      2'd2:    return (((x / 8 + y) % 2) == 1) ? 16'hFFFF : 16'h0000;
      default: return 16'h001F;                            // blue
    endcase
  endfunction

  // fields moved to the top of each channel with zeros below
  function automatic logic [23:0] expand(input display_pkg::pixel_t p);
    return {p[15:11], 3'b000, p[10:5], 2'b00, p[4:0], 3'b000};
  endfunction

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      hs_q       <= 1'b0;
      vs_q       <= 1'b0;
      act_q      <= 1'b0;
      hs_seen    <= 1'b0;
      vs_seen    <= 1'b0;
      hs_gap     <= 0;
      hs_len     <= 0;
      vs_gap     <= 0;
      px         <= 0;
      py         <= 0;
      frame_cnt  <= 0;
      check_from <= FIRST_FRAME;
      sel_q      <= pattern_sel_i;
      exp_sel    <= pattern_sel_i;
    end else begin
      hs_q   <= hsync_i;
      vs_q   <= vsync_i;
      act_q  <= active_i;
      hs_gap <= hs_rise ? 1 : hs_gap + 1;
      vs_gap <= vs_rise ? 1 : vs_gap + 1;
      hs_len <= hsync_i ? hs_len + 1 : 0;
      px     <= active_i ? px + 1 : 0;
      if (hs_rise) hs_seen <= 1'b1;
      if (vs_rise) begin
        vs_seen   <= 1'b1;
        frame_cnt <= frame_cnt + 1;
        py        <= 0;             // new frame starts at line 0
      end else if (act_fall) begin
        py <= py + 1;
      end
      sel_q <= pattern_sel_i;
      if (pattern_sel_i != sel_q) begin
        exp_sel    <= pattern_sel_i;
        check_from <= frame_cnt + 2;  // skip the frames still in flight
      end
    end
  end

  a_reset_out: assert property (@(posedge clk_camera)
    $past(recent_reset) |-> (rgb == '0 && !active_i && !hsync_i && !vsync_i))
    else begin error_count++; $error("Mismatch at %0t: output not cleared by reset", $time); end

  a_release: assert property (@(posedge clk_camera)
    $past(recent_reset, 2) |-> (!active_i && !hsync_i && !vsync_i))
    else begin error_count++; $error("Mismatch at %0t: level high after reset", $time); end

  a_hs_period: assert property (@(posedge clk_camera) disable iff (recent_reset)
    hs_rise && hs_seen |-> hs_gap == display_pkg::H_TOTAL)
    else begin
      error_count++;
      $error("Mismatch at %0t: hsync period %0d", $time, $sampled(hs_gap));
    end

  a_hs_width: assert property (@(posedge clk_camera) disable iff (recent_reset)
    $fell(hsync_i) |-> hs_len == display_pkg::HS_END - display_pkg::HS_START)
    else begin
      error_count++;
      $error("Mismatch at %0t: hsync width %0d", $time, $sampled(hs_len));
    end

  a_vs_period: assert property (@(posedge clk_camera) disable iff (recent_reset)
    vs_rise && vs_seen |-> vs_gap == display_pkg::H_TOTAL * display_pkg::V_TOTAL)
    else begin
      error_count++;
      $error("Mismatch at %0t: vsync period %0d", $time, $sampled(vs_gap));
    end

  a_line_len: assert property (@(posedge clk_camera) disable iff (recent_reset)
    act_fall |-> px == display_pkg::H_ACTIVE)
    else begin
      error_count++;
      $error("Mismatch at %0t: active run of %0d cycles", $time, $sampled(px));
    end

  a_frame_lines: assert property (@(posedge clk_camera) disable iff (recent_reset)
    vs_rise |-> py == display_pkg::V_ACTIVE)
    else begin
      error_count++;
      $error("Mismatch at %0t: %0d active lines in frame", $time, $sampled(py));
    end

  a_pixel: assert property (@(posedge clk_camera) disable iff (recent_reset)
    active_i && frame_cnt >= check_from |-> rgb == expand(ref_pixel(exp_sel, px, py)))
    else begin
      error_count++;
      $error("Mismatch at %0t: pixel (%0d,%0d) pattern %0d got %06h", $time,
             $sampled(px), $sampled(py), $sampled(exp_sel), $sampled(rgb));
    end

  a_blank: assert property (@(posedge clk_camera) disable iff (recent_reset)
    !active_i && frame_cnt >= FIRST_FRAME |-> rgb == expand(display_pkg::DEFAULT_PIXEL))
    else begin
      error_count++;
      $error("Mismatch at %0t: blanking color %06h", $time, $sampled(rgb));
    end

endmodule

//--- bench/tb_pattern_display.sv
module tb_pattern_display;

  localparam int FRAME_CYCLES = display_pkg::H_TOTAL * display_pkg::V_TOTAL;  // 480
  localparam int TIMEOUT      = (20 * FRAME_CYCLES + 1000) * 100;  // 20 frames and margin

  logic                      clk_camera;
  logic                      recent_reset;
  display_pkg::pattern_sel_t pattern_sel_i;
  display_pkg::color_t       red_o;
  display_pkg::color_t       green_o;
  display_pkg::color_t       blue_o;
  logic                      hsync_o;
  logic                      vsync_o;
  logic                      active_o;

  tb_clock #(.PERIOD(100)) u_tb_clock (.clk_o(clk_camera));

  pattern_display_top u_pattern_display_top (
    .clk_camera    (clk_camera),
    .recent_reset  (recent_reset),
    .pattern_sel_i (pattern_sel_i),
    .red_o         (red_o),
    .green_o       (green_o),
    .blue_o        (blue_o),
    .hsync_o       (hsync_o),
    .vsync_o       (vsync_o),
    .active_o      (active_o)
  );

  bind pattern_display_top pattern_display_sva u_sva (
    .clk_camera    (clk_camera),
    .recent_reset  (recent_reset),
    .pattern_sel_i (pattern_sel_i),
    .red_i         (red_o),
    .green_i       (green_o),
    .blue_i        (blue_o),
    .hsync_i       (hsync_o),
    .vsync_i       (vsync_o),
    .active_i      (active_o)
  );

  task automatic report_failure(input string why);
    $display("TESTS FAILED");
    $fatal(1, "%s", why);
  endtask

  // count frames by the output vsync
  task automatic wait_frames(input int n);
    repeat (n) @(posedge vsync_o);
  endtask

  task automatic show_pattern(input display_pkg::pattern_sel_t sel, input int frames);
    @(posedge clk_camera);
    pattern_sel_i <= sel;
    wait_frames(frames);
  endtask

  initial begin
    recent_reset  = 1'b1;
    pattern_sel_i = '0;
    repeat (3) @(posedge clk_camera);
    recent_reset <= 1'b0;
    wait_frames(5);          // color bars
    show_pattern(2'd1, 4);   // gradient
    show_pattern(2'd2, 4);   // checkerboard
    show_pattern(2'd3, 4);   // solid blue
    @(posedge clk_camera);
    if (u_pattern_display_top.u_sva.error_count == 0) begin
      $display("TESTS PASSED");
      $finish;
    end else begin
      report_failure("assertion errors counted at end of run");
    end
  end

  // stop at the first assertion error
  initial begin
    while (u_pattern_display_top.u_sva.error_count == 0) @(negedge clk_camera);
    report_failure("an assertion failed, see the Mismatch line above");
  end

  initial begin
    #(TIMEOUT);
    report_failure("watchdog expired before the frame sequence finished");
  end

endmodule

//--- pattern_display_top.f
common/display_pkg.sv
common/stream_if.sv
common/video_timing_if.sv
rtl/pattern_stacker.sv
rtl/chunk_fifo.sv
rtl/unstacker.sv
rtl/video_timing.sv
rtl/pixel_output.sv
rtl/pattern_display_top.sv
bench/tb_clock.sv
bench/pattern_display_sva.sv
bench/tb_pattern_display.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the pattern display testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tb_pattern_display \
  -f pattern_display_top.f -o sim_pattern_display
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/sim_pattern_display +verilator+error+limit+100
status=$?
if [ "$status" -ne 0 ]; then
  echo "simulation ended with status $status"
  exit "$status"
fi

exit 0
